/* rv32_lsu_pkg.sv */
`default_nettype none

package rv32_lsu_pkg;

  // memory opcodes that the core can hand to the load/store unit.
  // loads come first, then the three stores.
  typedef enum logic [3:0] {
    LB  = 4'd0,
    LH  = 4'd1,
    LW  = 4'd2,
    LBU = 4'd3,
    LHU = 4'd4,
    SB  = 4'd5,
    SH  = 4'd6,
    SW  = 4'd7
  } mem_op_e;

  // result code returned with every response.
  typedef enum logic [1:0] {
    ERR_NONE       = 2'd0,
    ERR_MISALIGNED = 2'd1,
    ERR_BUS        = 2'd2,
    ERR_TIMEOUT    = 2'd3
  } lsu_err_e;

  // states of the request sequencer.
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    CHECK      = 3'd1,
    WRITE_ADDR = 3'd2,
    WRITE_RESP = 3'd3,
    READ_ADDR  = 3'd4,
    READ_DATA  = 3'd5,
    RESPOND    = 3'd6,
    DRAIN      = 3'd7
  } lsu_state_e;

  // one memory request as the core presents it.
  typedef struct packed {
    mem_op_e     op;
    logic [31:0] base;
    logic [31:0] offset;
    logic [31:0] wdata;
  } lsu_req_t;

  // the single-cycle response back to the core.
  typedef struct packed {
    logic [31:0] rdata;
    lsu_err_e    err;
  } lsu_rsp_t;

  // AXI4-Lite signals driven by the master.
  typedef struct packed {
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
  } axil_m2s_t;

  // AXI4-Lite signals driven by the slave.
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_s2m_t;

  // every other response code counts as a bus error.
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* agu.sv */
`timescale 1ns/100ps
`default_nettype none

module agu (
  input  rv32_lsu_pkg::lsu_req_t cur_req,
  output logic [31:0]            address,
  output logic [3:0]             byte_en,
  output logic                   misaligned
);

  import rv32_lsu_pkg::*;

  logic [1:0] byte_offset;

  // the effective address is base plus the sign-extended immediate.
  // the core has already extended the immediate to 32 bits.
  assign address     = cur_req.base + cur_req.offset;
  assign byte_offset = address[1:0];

  // byte enables follow the access size and the low address bits.
  // a misaligned halfword still gets some enable pattern here, but the
  // misaligned flag keeps it off the bus.
  always_comb begin
    case (cur_req.op)
      LB, LBU, SB: begin
        byte_en = 4'b0001 << byte_offset;
      end
      LH, LHU, SH: begin
        byte_en = byte_offset[1] ? 4'b1100 : 4'b0011;
      end
      LW, SW: begin
        byte_en = 4'b1111;
      end
      default: begin
        byte_en = 4'b0000;
      end
    endcase
  end

  // alignment is judged on the formed address and the opcode.
  // byte accesses can never be misaligned.
  always_comb begin
    case (cur_req.op)
      LH, LHU, SH: begin
        misaligned = byte_offset[0];
      end
      LW, SW: begin
        misaligned = (byte_offset != 2'b00);
      end
      default: begin
        misaligned = 1'b0;
      end
    endcase
  end

  // an aligned access must present exactly one legal lane pattern,
  // otherwise the enable decode and the alignment check disagree.
  always_comb begin
    assert final ($isunknown(cur_req.op) || misaligned ||
                  byte_en inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                  4'b0011, 4'b1100, 4'b1111})
      else $error("agu: illegal byte enable %b for aligned access", byte_en);
  end

endmodule

`default_nettype wire

/* lane_align.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_align (
  input  rv32_lsu_pkg::mem_op_e op,
  input  logic [1:0]            addr_low,
  input  logic [31:0]           store_data,
  input  logic [31:0]           bus_rdata,
  output logic [31:0]           lane_wdata,
  output logic [31:0]           load_data
);

  import rv32_lsu_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // narrow stores are copied onto every lane they could land on.
  // the write strobe then picks the lanes that really change, so no
  // shifter is needed on the store path.
  always_comb begin
    case (op)
      SB: begin
        lane_wdata = {4{store_data[7:0]}};
      end
      SH: begin
        lane_wdata = {2{store_data[15:0]}};
      end
      default: begin
        lane_wdata = store_data;
      end
    endcase
  end

  // pick the addressed byte and halfword out of the read word.
  // bit 0 of the address is ignored for halfwords since a misaligned
  // halfword never reaches the bus.
  assign sel_byte = bus_rdata[{addr_low, 3'b000} +: 8];
  assign sel_half = addr_low[1] ? bus_rdata[31:16] : bus_rdata[15:0];

  // move the selected field to bit 0 and extend it.
  // signed loads copy the top bit, unsigned loads fill with zeros.
  always_comb begin
    case (op)
      LB: begin
        load_data = {{24{sel_byte[7]}}, sel_byte};
      end
      LBU: begin
        load_data = {24'd0, sel_byte};
      end
      LH: begin
        load_data = {{16{sel_half[15]}}, sel_half};
      end
      LHU: begin
        load_data = {16'd0, sel_half};
      end
      default: begin
        load_data = bus_rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

/* bus_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_timer #(
  parameter int unsigned TIMEOUT_CYCLES = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic run,
  output logic expired
);

  // the counter must be able to hold TIMEOUT_CYCLES itself.
  localparam int unsigned COUNT_W = $clog2(TIMEOUT_CYCLES + 1);

  logic [COUNT_W-1:0] count;

  // count the cycles spent waiting and start over whenever run drops.
  // the count stops at the limit so it can never wrap back to zero.
  always_ff @(posedge clk) begin
    if (rst || !run) begin
      count <= '0;
    end else if (count != COUNT_W'(TIMEOUT_CYCLES)) begin
      count <= count + 1'b1;
    end
  end

  // the count still holds its old value in the cycle run falls,
  // so run qualifies the compare.
  assign expired = run && (count == COUNT_W'(TIMEOUT_CYCLES));

  // once the watchdog fires, the waiting side must stop waiting.
  assert property (@(posedge clk) disable iff (rst)
    expired |=> !run)
    else $error("bus_timer: run still high after expiry");

endmodule

`default_nettype wire

/* lsu_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_valid,
  input  rv32_lsu_pkg::lsu_req_t  req,
  output logic                    req_ready,
  output logic                    rsp_valid,
  output rv32_lsu_pkg::lsu_rsp_t  rsp,
  output rv32_lsu_pkg::lsu_req_t  cur_req,
  input  logic [31:0]             address,
  input  logic [3:0]              byte_en,
  input  logic                    misaligned,
  input  logic [31:0]             lane_wdata,
  input  logic [31:0]             load_data,
  output logic                    timer_run,
  input  logic                    expired,
  output rv32_lsu_pkg::axil_m2s_t axi_out,
  input  rv32_lsu_pkg::axil_s2m_t axi_in
);

  import rv32_lsu_pkg::*;

  lsu_state_e  state;
  lsu_state_e  state_next;
  lsu_err_e    err_q;
  logic [31:0] rdata_q;
  logic        is_store;
  logic        bus_busy;
  logic        issue;
  logic        aw_done;
  logic        w_done;
  logic        ar_done;
  logic        aw_hs;
  logic        w_hs;
  logic        ar_hs;
  logic        b_hs;
  logic        r_hs;

  assign is_store = cur_req.op inside {SB, SH, SW};

  // the address phase starts in CHECK once the request is known to be
  // aligned, and stays open until each channel has seen its ready.
  assign issue = bus_busy || (state == CHECK && !misaligned);

  always_comb begin
    axi_out.awvalid = issue && is_store && !aw_done;
    axi_out.awaddr  = address;
    axi_out.wvalid  = issue && is_store && !w_done;
    axi_out.wdata   = lane_wdata;
    axi_out.wstrb   = byte_en;
    axi_out.bready  = (state == WRITE_RESP) || (state == DRAIN && is_store);
    axi_out.arvalid = issue && !is_store && !ar_done;
    axi_out.araddr  = address;
    axi_out.rready  = (state == READ_DATA) || (state == DRAIN && !is_store);
  end

  assign aw_hs = axi_out.awvalid && axi_in.awready;
  assign w_hs  = axi_out.wvalid && axi_in.wready;
  assign ar_hs = axi_out.arvalid && axi_in.arready;
  assign b_hs  = axi_out.bready && axi_in.bvalid;
  assign r_hs  = axi_out.rready && axi_in.rvalid;

  // the request is only captured on acceptance.
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      cur_req <= req;
    end
  end

  // per-channel done flags. they are cleared in IDLE so that a
  // timed-out request keeps its valids up through RESPOND and DRAIN.
  always_ff @(posedge clk) begin
    if (rst || state == IDLE) begin
      bus_busy <= 1'b0;
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
      ar_done  <= 1'b0;
    end else begin
      if (state == CHECK && !misaligned) begin
        bus_busy <= 1'b1;
      end
      if (aw_hs) begin
        aw_done <= 1'b1;
      end
      if (w_hs) begin
        w_done <= 1'b1;
      end
      if (ar_hs) begin
        ar_done <= 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_valid) begin
          state_next = CHECK;
        end
      end
      CHECK: begin
        if (misaligned) begin
          state_next = RESPOND;
        end else if (is_store) begin
          state_next = WRITE_ADDR;
        end else begin
          state_next = READ_ADDR;
        end
      end
      WRITE_ADDR: begin
        if (expired) begin
          state_next = RESPOND;
        end else if ((aw_done || aw_hs) && (w_done || w_hs)) begin
          state_next = WRITE_RESP;
        end
      end
      READ_ADDR: begin
        if (expired) begin
          state_next = RESPOND;
        end else if (ar_done || ar_hs) begin
          state_next = READ_DATA;
        end
      end
      // a response that arrives together with expiry still wins.
      WRITE_RESP, READ_DATA: begin
        if (b_hs || r_hs || expired) begin
          state_next = RESPOND;
        end
      end
      RESPOND: begin
        state_next = (err_q == ERR_TIMEOUT) ? DRAIN : IDLE;
      end
      DRAIN: begin
        if (b_hs || r_hs) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // result capture. load data is only stable during the R handshake,
  // so it is sampled there and held for the RESPOND cycle.
  // stores and failed loads report zero data.
  always_ff @(posedge clk) begin
    if (rst) begin
      err_q <= ERR_NONE;
    end else if (state == CHECK) begin
      err_q <= misaligned ? ERR_MISALIGNED : ERR_NONE;
    end else if (state == WRITE_RESP && b_hs) begin
      err_q <= (axi_in.bresp == RESP_OKAY) ? ERR_NONE : ERR_BUS;
    end else if (state == READ_DATA && r_hs) begin
      err_q <= (axi_in.rresp == RESP_OKAY) ? ERR_NONE : ERR_BUS;
    end else if (expired) begin
      err_q <= ERR_TIMEOUT;
    end
  end

  always_ff @(posedge clk) begin
    if (state == CHECK) begin
      rdata_q <= '0;
    end else if (state == READ_DATA && r_hs && axi_in.rresp == RESP_OKAY) begin
      rdata_q <= load_data;
    end
  end

  assign req_ready = (state == IDLE);
  assign rsp_valid = (state == RESPOND);
  assign rsp.rdata = rdata_q;
  assign rsp.err   = err_q;

  // the watchdog runs from the first address cycle until a response.
  assign timer_run = (state == CHECK && !misaligned) || (state == WRITE_ADDR) ||
                     (state == WRITE_RESP) || (state == READ_ADDR) ||
                     (state == READ_DATA);

  // address valids hold with a stable address until accepted.
  assert property (@(posedge clk) disable iff (rst)
    axi_out.awvalid && !axi_in.awready |=> axi_out.awvalid && $stable(axi_out.awaddr))
    else $error("lsu_fsm: awvalid dropped before awready");

  assert property (@(posedge clk) disable iff (rst)
    axi_out.arvalid && !axi_in.arready |=> axi_out.arvalid && $stable(axi_out.araddr))
    else $error("lsu_fsm: arvalid dropped before arready");

  // every request gets exactly one response pulse.
  assert property (@(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid)
    else $error("lsu_fsm: rsp_valid held for two cycles");

endmodule

`default_nettype wire

/* lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
  parameter int unsigned TIMEOUT_CYCLES = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_valid,
  input  rv32_lsu_pkg::lsu_req_t  req,
  output logic                    req_ready,
  output logic                    rsp_valid,
  output rv32_lsu_pkg::lsu_rsp_t  rsp,
  output rv32_lsu_pkg::axil_m2s_t axi_out,
  input  rv32_lsu_pkg::axil_s2m_t axi_in
);

  import rv32_lsu_pkg::*;

  // the latched request fans out to the address and lane logic.
  lsu_req_t    cur_req;
  logic [31:0] address;
  logic [3:0]  byte_en;
  logic        misaligned;
  logic [31:0] lane_wdata;
  logic [31:0] load_data;
  logic        timer_run;
  logic        expired;

  agu agu_inst (
    .cur_req    (cur_req),
    .address    (address),
    .byte_en    (byte_en),
    .misaligned (misaligned)
  );

  // read data goes straight from the bus into the extender.
  lane_align lane_align_inst (
    .op         (cur_req.op),
    .addr_low   (address[1:0]),
    .store_data (cur_req.wdata),
    .bus_rdata  (axi_in.rdata),
    .lane_wdata (lane_wdata),
    .load_data  (load_data)
  );

  bus_timer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) bus_timer_inst (
    .clk     (clk),
    .rst     (rst),
    .run     (timer_run),
    .expired (expired)
  );

  lsu_fsm lsu_fsm_inst (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .cur_req    (cur_req),
    .address    (address),
    .byte_en    (byte_en),
    .misaligned (misaligned),
    .lane_wdata (lane_wdata),
    .load_data  (load_data),
    .timer_run  (timer_run),
    .expired    (expired),
    .axi_out    (axi_out),
    .axi_in     (axi_in)
  );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int unsigned HALF_PERIOD = 10
) (
  output logic clk
);

  // free-running clock, low at time zero, toggling every half period.
  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mem #(
  parameter int unsigned SLOW_DELAY = 40
) (
  input  logic                    clk,
  input  logic                    rst,
  input  rv32_lsu_pkg::axil_m2s_t axi_out,
  output rv32_lsu_pkg::axil_s2m_t axi_in
);

  import rv32_lsu_pkg::*;

  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // 256 words of storage, so address bits 9:2 pick the word.
  logic [31:0] mem [256];
  axil_m2s_t   seen;
  logic [31:0] aw_addr;
  logic        aw_got;
  logic [31:0] w_data;
  logic [3:0]  w_strb;
  logic        w_got;
  logic [31:0] ar_addr;
  logic        ar_got;
  logic        b_pend;
  logic        r_pend;
  int unsigned aw_wait;
  int unsigned w_wait;
  int unsigned ar_wait;
  int unsigned b_wait;
  int unsigned r_wait;

  // addresses with bit 12 set belong to the slow region.
  function automatic int unsigned response_delay(input logic [31:0] addr);
    if (addr[12]) begin
      return SLOW_DELAY;
    end
    return $urandom_range(0, 3);
  endfunction

  // all slave outputs change on the falling edge only.
  // seen holds the master outputs as they stood at the last rising edge,
  // so a handshake is valid in seen and ready in the current axi_in.
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h0104_0401) ^ 32'h5a00_c3a5;
    end
    axi_in = '0;
    seen   = '0;
    forever begin
      @(negedge clk);
      if (rst) begin
        axi_in  = '0;
        seen    = '0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
        ar_got  = 1'b0;
        b_pend  = 1'b0;
        r_pend  = 1'b0;
        aw_wait = $urandom_range(0, 3);
        w_wait  = $urandom_range(0, 3);
        ar_wait = $urandom_range(0, 3);
      end else begin
        // retire the handshakes of the last rising edge.
        if (seen.awvalid && axi_in.awready) begin
          aw_got  = 1'b1;
          aw_addr = seen.awaddr;
        end
        if (seen.wvalid && axi_in.wready) begin
          w_got  = 1'b1;
          w_data = seen.wdata;
          w_strb = seen.wstrb;
        end
        if (seen.arvalid && axi_in.arready) begin
          ar_got  = 1'b1;
          ar_addr = seen.araddr;
        end
        if (seen.bready && axi_in.bvalid) begin
          axi_in.bvalid = 1'b0;
          b_pend  = 1'b0;
          aw_got  = 1'b0;
          w_got   = 1'b0;
          aw_wait = $urandom_range(0, 3);
          w_wait  = $urandom_range(0, 3);
        end
        if (seen.rready && axi_in.rvalid) begin
          axi_in.rvalid = 1'b0;
          r_pend  = 1'b0;
          ar_got  = 1'b0;
          ar_wait = $urandom_range(0, 3);
        end

        // every ready is a one-cycle pulse after a random wait.
        axi_in.awready = 1'b0;
        axi_in.wready  = 1'b0;
        axi_in.arready = 1'b0;
        if (axi_out.awvalid && !aw_got) begin
          if (aw_wait == 0) axi_in.awready = 1'b1;
          else aw_wait--;
        end
        if (axi_out.wvalid && !w_got) begin
          if (w_wait == 0) axi_in.wready = 1'b1;
          else w_wait--;
        end
        if (axi_out.arvalid && !ar_got) begin
          if (ar_wait == 0) axi_in.arready = 1'b1;
          else ar_wait--;
        end

        // the write lands once address and data are both in.
        // the error region (bit 13) leaves memory untouched.
        if (aw_got && w_got && !b_pend) begin
          b_pend = 1'b1;
          b_wait = response_delay(aw_addr);
          if (!aw_addr[13]) begin
            for (int lane = 0; lane < 4; lane++) begin
              if (w_strb[lane]) begin
                mem[aw_addr[9:2]][8*lane +: 8] = w_data[8*lane +: 8];
              end
            end
          end
        end
        if (b_pend && !axi_in.bvalid) begin
          if (b_wait == 0) begin
            axi_in.bvalid = 1'b1;
            axi_in.bresp  = aw_addr[13] ? RESP_SLVERR : RESP_OKAY;
          end else begin
            b_wait--;
          end
        end

        // an error response still carries stale word data on rdata,
        // which the master has to drop.
        if (ar_got && !r_pend) begin
          r_pend = 1'b1;
          r_wait = response_delay(ar_addr);
        end
        if (r_pend && !axi_in.rvalid) begin
          if (r_wait == 0) begin
            axi_in.rvalid = 1'b1;
            axi_in.rdata  = mem[ar_addr[9:2]];
            axi_in.rresp  = ar_addr[13] ? RESP_SLVERR : RESP_OKAY;
          end else begin
            r_wait--;
          end
        end
        seen = axi_out;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_lsu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

  import rv32_lsu_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 16;
  localparam int unsigned SLOW_DELAY     = 40;
  localparam int unsigned RESET_CYCLES   = 5;
  // 14 + 5 + 6 + 3 + 58 + 4 requests over the six tests.
  localparam int unsigned NUM_REQUESTS   = 90;
  localparam int unsigned CYCLE_LIMIT    =
    NUM_REQUESTS * (TIMEOUT_CYCLES + SLOW_DELAY + 20) + RESET_CYCLES;

  localparam logic [31:0] WORD_ADDR   = 32'h0000_0100;
  localparam logic [31:0] MERGE_ADDR  = 32'h0000_0140;
  localparam logic [31:0] ALIGN_ADDR  = 32'h0000_0180;
  localparam logic [31:0] WINDOW_ADDR = 32'h0000_0200;
  localparam logic [31:0] ERROR_BASE  = 32'h0000_2000;
  localparam logic [31:0] SLOW_BASE   = 32'h0000_1000;
  // byte 0 and the upper half are negative, byte 1 and the lower half are not.
  localparam logic [31:0] WORD_DATA   = 32'h80f1_7f92;

  logic        clk;
  logic        rst;
  logic        req_valid;
  logic        req_ready;
  logic        rsp_valid;
  lsu_req_t    req;
  lsu_rsp_t    rsp;
  axil_m2s_t   axi_out;
  axil_s2m_t   axi_in;
  int unsigned cycle_count;
  int unsigned error_count;
  logic [31:0] shadow [8];

  tb_clock #(.HALF_PERIOD(10)) tb_clock_inst (.clk(clk));

  tb_axi_mem #(.SLOW_DELAY(SLOW_DELAY)) tb_axi_mem_inst (
    .clk     (clk),
    .rst     (rst),
    .axi_out (axi_out),
    .axi_in  (axi_in)
  );

  lsu_top #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) lsu_top_inst (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .axi_out   (axi_out),
    .axi_in    (axi_in)
  );

  // the memory word after a store, where only the addressed lanes change.
  function automatic logic [31:0] merge_store(input logic [31:0] old_word, input mem_op_e op,
                                              input logic [1:0] low, input logic [31:0] data);
    logic [31:0] mask;
    case (op)
      SB:      mask = 32'h0000_00ff << {low, 3'b000};
      SH:      mask = 32'h0000_ffff << {low, 3'b000};
      default: mask = 32'hffff_ffff;
    endcase
    return (old_word & ~mask) | ((data << {low, 3'b000}) & mask);
  endfunction

  // the register value a load returns from one memory word.
  function automatic logic [31:0] extract_load(input logic [31:0] word, input mem_op_e op,
                                               input logic [1:0] low);
    logic [31:0] field;
    field = word >> {low, 3'b000};
    case (op)
      LB:      return {{24{field[7]}}, field[7:0]};
      LBU:     return {24'd0, field[7:0]};
      LH:      return {{16{field[15]}}, field[15:0]};
      LHU:     return {16'd0, field[15:0]};
      default: return word;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // one request from the core side, entered and left on a falling edge.
  // the address is split into base and a random signed offset so the adder
  // sees carries and negative immediates.
  task automatic issue_request(input mem_op_e op, input logic [31:0] addr,
                               input logic [31:0] wdata, output lsu_rsp_t result,
                               output int unsigned latency, output logic bus_used);
    logic [31:0] offset;
    offset     = $urandom_range(0, 63) - 32'd32;
    req.op     = op;
    req.base   = addr - offset;
    req.offset = offset;
    req.wdata  = wdata;
    req_valid  = 1'b1;
    bus_used   = 1'b0;
    while (!req_ready) begin
      @(negedge clk);
    end
    // ready is high here, so the next rising edge accepts the request.
    @(negedge clk);
    req_valid = 1'b0;
    latency   = 1;
    while (!rsp_valid) begin
      if (axi_out.awvalid || axi_out.wvalid || axi_out.arvalid) bus_used = 1'b1;
      @(negedge clk);
      latency++;
    end
    result = rsp;
  endtask

  task automatic access_and_check(input mem_op_e op, input logic [31:0] addr,
                                  input logic [31:0] wdata, input logic [31:0] exp_data,
                                  input lsu_err_e exp_err);
    lsu_rsp_t    result;
    int unsigned latency;
    logic        bus_used;
    issue_request(op, addr, wdata, result, latency, bus_used);
    check_value($sformatf("rsp.rdata of %s at 0x%08h", op.name(), addr),
                result.rdata, exp_data);
    check_value($sformatf("rsp.err of %s at 0x%08h", op.name(), addr),
                32'(result.err), 32'(exp_err));
  endtask

  // after reset the unit is idle, ready for work and quiet on the bus.
  task automatic idle_outputs_after_reset();
    check_value("req_ready", 32'(req_ready), 32'd1);
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    check_value("axi_out.awvalid", 32'(axi_out.awvalid), 32'd0);
    check_value("axi_out.wvalid", 32'(axi_out.wvalid), 32'd0);
    check_value("axi_out.arvalid", 32'(axi_out.arvalid), 32'd0);
    check_value("axi_out.bready", 32'(axi_out.bready), 32'd0);
    check_value("axi_out.rready", 32'(axi_out.rready), 32'd0);
  endtask

  // word store, then every load size at every legal offset.
  task automatic word_and_subword_loads();
    access_and_check(SW, WORD_ADDR, WORD_DATA, 32'd0, ERR_NONE);
    access_and_check(LW, WORD_ADDR, 32'd0, WORD_DATA, ERR_NONE);
    for (int low = 0; low < 4; low += 2) begin
      access_and_check(LH, WORD_ADDR + 32'(low), 32'd0,
                       extract_load(WORD_DATA, LH, 2'(low)), ERR_NONE);
      access_and_check(LHU, WORD_ADDR + 32'(low), 32'd0,
                       extract_load(WORD_DATA, LHU, 2'(low)), ERR_NONE);
    end
    for (int low = 0; low < 4; low++) begin
      access_and_check(LB, WORD_ADDR + 32'(low), 32'd0,
                       extract_load(WORD_DATA, LB, 2'(low)), ERR_NONE);
      access_and_check(LBU, WORD_ADDR + 32'(low), 32'd0,
                       extract_load(WORD_DATA, LBU, 2'(low)), ERR_NONE);
    end
  endtask

  // narrow stores carry junk in the unused bits, which must not land.
  task automatic lane_merge_stores();
    logic [31:0] expected;
    expected = 32'h1111_1111;
    access_and_check(SW, MERGE_ADDR, expected, 32'd0, ERR_NONE);
    access_and_check(SB, MERGE_ADDR + 32'd1, 32'hffff_ffa5, 32'd0, ERR_NONE);
    expected = merge_store(expected, SB, 2'd1, 32'hffff_ffa5);
    access_and_check(SH, MERGE_ADDR + 32'd2, 32'hdead_5a3c, 32'd0, ERR_NONE);
    expected = merge_store(expected, SH, 2'd2, 32'hdead_5a3c);
    access_and_check(SB, MERGE_ADDR, 32'h0000_770f, 32'd0, ERR_NONE);
    expected = merge_store(expected, SB, 2'd0, 32'h0000_770f);
    access_and_check(LW, MERGE_ADDR, 32'd0, expected, ERR_NONE);
  endtask

  // misaligned requests answer two cycles after acceptance without bus traffic.
  task automatic misaligned_requests();
    mem_op_e     ops [4];
    int unsigned lows [4];
    lsu_rsp_t    result;
    int unsigned latency;
    logic        bus_used;
    ops  = '{LH, LW, SH, SW};
    lows = '{1, 2, 3, 1};
    access_and_check(SW, ALIGN_ADDR, 32'h1357_9bdf, 32'd0, ERR_NONE);
    for (int i = 0; i < 4; i++) begin
      issue_request(ops[i], ALIGN_ADDR + 32'(lows[i]), 32'h0000_ffff, result, latency,
                    bus_used);
      check_value("rsp.err", 32'(result.err), 32'(ERR_MISALIGNED));
      check_value("rsp.rdata", result.rdata, 32'd0);
      check_value("response latency", 32'(latency), 32'd2);
      check_value("axi valid raised", 32'(bus_used), 32'd0);
    end
    access_and_check(LW, ALIGN_ADDR, 32'd0, 32'h1357_9bdf, ERR_NONE);
  endtask

  task automatic bus_error_region();
    access_and_check(SW, ERROR_BASE + 32'h40, 32'hcafe_f00d, 32'd0, ERR_BUS);
    access_and_check(LW, ERROR_BASE + 32'h40, 32'd0, 32'd0, ERR_BUS);
    access_and_check(LB, ERROR_BASE + 32'h43, 32'd0, 32'd0, ERR_BUS);
  endtask

  // random traffic in an eight-word window, checked against the shadow copy.
  task automatic random_back_pressure();
    mem_op_e     op;
    int unsigned idx;
    logic [1:0]  low;
    logic [31:0] data;
    logic [31:0] addr;
    for (int i = 0; i < 8; i++) begin
      data      = $urandom();
      shadow[i] = data;
      access_and_check(SW, WINDOW_ADDR + 32'(i * 4), data, 32'd0, ERR_NONE);
    end
    for (int n = 0; n < 50; n++) begin
      op  = mem_op_e'(4'($urandom_range(0, 7)));
      idx = $urandom_range(0, 7);
      case (op)
        LB, LBU, SB: low = 2'($urandom_range(0, 3));
        LH, LHU, SH: low = {1'($urandom_range(0, 1)), 1'b0};
        default:     low = 2'd0;
      endcase
      addr = WINDOW_ADDR + 32'(idx * 4) + 32'(low);
      data = $urandom();
      if (op inside {SB, SH, SW}) begin
        shadow[idx] = merge_store(shadow[idx], op, low, data);
        access_and_check(op, addr, data, 32'd0, ERR_NONE);
      end else begin
        access_and_check(op, addr, 32'd0, extract_load(shadow[idx], op, low), ERR_NONE);
      end
    end
  endtask

  // the slow region answers after the watchdog, and the unit recovers.
  task automatic slow_region_timeout();
    access_and_check(LW, SLOW_BASE + 32'h240, 32'd0, 32'd0, ERR_TIMEOUT);
    access_and_check(LW, WORD_ADDR, 32'd0, WORD_DATA, ERR_NONE);
    access_and_check(SW, SLOW_BASE + 32'h280, 32'h0bad_beef, 32'd0, ERR_TIMEOUT);
    access_and_check(LW, WINDOW_ADDR, 32'd0, shadow[0], ERR_NONE);
  endtask

  // watchdog on total simulation length.
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
        $display("timeout: no result after %0d cycles, the DUT stopped answering",
                 CYCLE_LIMIT);
        $display("TEST FAILED");
        $fatal(1, "cycle limit reached");
      end
    end
  end

  initial begin
    void'($urandom(32'hbefe));
    error_count = 0;
    rst         = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle_outputs_after_reset();
    word_and_subword_loads();
    lane_merge_stores();
    misaligned_requests();
    bus_error_region();
    random_back_pressure();
    slow_region_timeout();
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rv32_lsu_pkg.sv
agu.sv
lane_align.sv
bus_timer.sv
lsu_fsm.sv
lsu_top.sv
tb_clock.sv
tb_axi_mem.sv
tb_lsu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lsu -f vlog.f -o tb_lsu_sim

# the simulator exits non-zero on a fatal check, so its output is searched instead.
sim_output=$(./obj_dir/tb_lsu_sim 2>&1 || true)
echo "$sim_output"

if echo "$sim_output" | grep -qx "TEST OK"; then
  echo "simulation passed"
else
  echo "simulation did not pass"
  exit 1
fi
